// ==== execCore_settings.svh ====
`ifndef EXEC_CORE_SETTINGS_SVH
`define EXEC_CORE_SETTINGS_SVH

// Width of every data word in the execute path
`define EXEC_DATA_WIDTH 16

// Entries in the decoded-operation FIFO
// Any power of two of 2 or more works
`define EXEC_QUEUE_DEPTH 4

`endif

// ==== execPkg.sv ====
`default_nettype none

package execPkg;

    // Opcode encodings of the teaching ISA
    typedef enum logic [4:0] {
        ADDR  = 5'b00000,
        SUBR  = 5'b00001,
        XORR  = 5'b00010,
        ANDNR = 5'b00011,
        ROLR  = 5'b00100,
        SLLR  = 5'b00101,
        RORR  = 5'b00110,
        SRLR  = 5'b00111,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        BLTZ  = 5'b01110,
        BGEZ  = 5'b01111,
        SLBI  = 5'b10010,
        ROLI  = 5'b10100,
        SLLI  = 5'b10101,
        RORI  = 5'b10110,
        SRLI  = 5'b10111,
        LBI   = 5'b11000,
        BTR   = 5'b11001,
        SEQ   = 5'b11100,
        SLT   = 5'b11101,
        SLE   = 5'b11110,
        SCO   = 5'b11111
    } opcodeT;

    // Low two bits follow the opcode's function bits
    typedef enum logic [2:0] {ADD, SUB, XOR, ANDN, ROL, SLL, ROR, SRL} aluOpT;

    typedef enum logic [1:0] {EQ, LT, LE, CARRY} setCondT;

    typedef enum logic [1:0] {ALU, SET, REVERSE, BYTEIMM} resultSelT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] spare;
    } rFormT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm5;
    } iFormT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [7:0] imm8;
    } jFormT;

    // One fetched word seen through each instruction format
    typedef union packed {
        rFormT rForm;
        iFormT iForm;
        jFormT jForm;
    } instrWordT;

endpackage

`default_nettype wire

// ==== execBus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "execCore_settings.svh"

interface execBus import execPkg::*; ();
    logic                        valid;
    aluOpT                       aluOp;
    logic                        useImm;
    // Adder forms inA minus inB
    logic                        invertB;
    setCondT                     setCond;
    resultSelT                   resultSel;
    logic                        isBranch;
    logic [`EXEC_DATA_WIDTH-1:0] immVal;
    logic [`EXEC_DATA_WIDTH-1:0] opA;
    logic [`EXEC_DATA_WIDTH-1:0] opB;
    logic [2:0]                  destReg;

    modport source (
        output valid, aluOp, useImm, invertB, setCond, resultSel,
        output isBranch, immVal, opA, opB, destReg
    );

    modport sink (
        input valid, aluOp, useImm, invertB, setCond, resultSel,
        input isBranch, immVal, opA, opB, destReg
    );
endinterface

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "execCore_settings.svh"

module instrDecoder import execPkg::*; (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        instrValid,
    input  instrWordT                   instr,
    input  logic [`EXEC_DATA_WIDTH-1:0] rsData,
    input  logic [`EXEC_DATA_WIDTH-1:0] rtData,
    execBus.source                      busIn
);
    localparam int W = `EXEC_DATA_WIDTH;

    logic [4:0]   opBits;
    aluOpT        aluOpNext;
    logic         useImmNext;
    logic         invertBNext;
    setCondT      setCondNext;
    resultSelT    resultSelNext;
    logic         isBranchNext;
    logic [W-1:0] immNext;
    logic [2:0]   destNext;
    logic         opKnown;

    assign opBits = instr.rForm.opcode;

    always_comb begin
        aluOpNext     = ADD;
        useImmNext    = 1'b0;
        invertBNext   = 1'b0;
        setCondNext   = EQ;
        resultSelNext = ALU;
        isBranchNext  = 1'b0;
        immNext       = '0;
        destNext      = instr.rForm.rd;
        opKnown       = 1'b1;
        case (instr.rForm.opcode)
            ADDR, SUBR, XORR, ANDNR, ROLR, SLLR, RORR, SRLR:
                aluOpNext = aluOpT'(opBits[2:0]);
            ADDI, SUBI, XORI, ROLI, SLLI, RORI, SRLI: begin
                // Bit 4 splits arithmetic from shift immediates
                aluOpNext  = aluOpT'({opBits[4], opBits[1:0]});
                useImmNext = 1'b1;
                immNext    = {{(W-5){instr.iForm.imm5[4]}}, instr.iForm.imm5};
                destNext   = instr.iForm.rd;
            end
            ANDNI: begin
                aluOpNext  = ANDN;
                useImmNext = 1'b1;
                immNext    = {{(W-5){1'b0}}, instr.iForm.imm5};
                destNext   = instr.iForm.rd;
            end
            SEQ, SLT, SLE, SCO: begin
                // Compares need rs minus rt, carry needs rs plus rt
                invertBNext   = (instr.rForm.opcode != SCO);
                setCondNext   = setCondT'(opBits[1:0]);
                resultSelNext = SET;
            end
            BTR:
                resultSelNext = REVERSE;
            LBI: begin
                resultSelNext = BYTEIMM;
                immNext       = {{(W-8){instr.jForm.imm8[7]}}, instr.jForm.imm8};
                destNext      = instr.jForm.rs;
            end
            SLBI: begin
                resultSelNext = BYTEIMM;
                useImmNext    = 1'b1;
                immNext       = {{(W-8){1'b0}}, instr.jForm.imm8};
                destNext      = instr.jForm.rs;
            end
            BEQZ, BNEZ, BLTZ, BGEZ: begin
                isBranchNext = 1'b1;
                destNext     = 3'd0;
            end
            default:
                opKnown = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busIn.valid <= 1'b0;
        end else begin
            busIn.valid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            busIn.aluOp     <= aluOpNext;
            busIn.useImm    <= useImmNext;
            busIn.invertB   <= invertBNext;
            busIn.setCond   <= setCondNext;
            busIn.resultSel <= resultSelNext;
            busIn.isBranch  <= isBranchNext;
            busIn.immVal    <= immNext;
            busIn.opA       <= rsData;
            busIn.opB       <= useImmNext ? immNext : rtData;
            busIn.destReg   <= destNext;
        end
    end

    // Only supported opcodes may be issued
    assert property (@(posedge clk) disable iff (!rstN) instrValid |-> opKnown);

endmodule

`default_nettype wire

// ==== opQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "execCore_settings.svh"

module opQueue import execPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   pop,
    execBus.sink   busIn,
    execBus.source busOut,
    output logic   full
);
    localparam int Depth = `EXEC_QUEUE_DEPTH;
    localparam int PtrW  = $clog2(Depth);

    typedef struct packed {
        aluOpT                       aluOp;
        logic                        useImm;
        logic                        invertB;
        setCondT                     setCond;
        resultSelT                   resultSel;
        logic                        isBranch;
        logic [`EXEC_DATA_WIDTH-1:0] immVal;
        logic [`EXEC_DATA_WIDTH-1:0] opA;
        logic [`EXEC_DATA_WIDTH-1:0] opB;
        logic [2:0]                  destReg;
    } entryT;

    entryT           mem [Depth];
    entryT           wrEntry;
    entryT           head;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count;

    assign wrEntry = '{busIn.aluOp, busIn.useImm, busIn.invertB, busIn.setCond,
                       busIn.resultSel, busIn.isBranch, busIn.immVal, busIn.opA,
                       busIn.opB, busIn.destReg};

    always_ff @(posedge clk) begin
        if (busIn.valid) begin
            mem[wrPtr] <= wrEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (busIn.valid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (busIn.valid && !pop) begin
                count <= count + 1'b1;
            end else if (!busIn.valid && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry falls through straight from storage
    assign head             = mem[rdPtr];
    assign busOut.valid     = (count != '0);
    assign busOut.aluOp     = head.aluOp;
    assign busOut.useImm    = head.useImm;
    assign busOut.invertB   = head.invertB;
    assign busOut.setCond   = head.setCond;
    assign busOut.resultSel = head.resultSel;
    assign busOut.isBranch  = head.isBranch;
    assign busOut.immVal    = head.immVal;
    assign busOut.opA       = head.opA;
    assign busOut.opB       = head.opB;
    assign busOut.destReg   = head.destReg;

    // One slot early since the decoder holds one more op in flight
    assign full = (count >= (Depth - 1));

    assert property (@(posedge clk) disable iff (!rstN) busIn.valid |-> count != Depth);
    assert property (@(posedge clk) disable iff (!rstN) pop |-> count != '0);

endmodule

`default_nettype wire

// ==== aluCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "execCore_settings.svh"

module aluCore import execPkg::*; (
    input  logic [`EXEC_DATA_WIDTH-1:0] inA,
    input  logic [`EXEC_DATA_WIDTH-1:0] inB,
    input  aluOpT                       aluOp,
    input  logic                        invertB,
    output logic [`EXEC_DATA_WIDTH-1:0] out,
    output logic                        zero,
    output logic                        ltz,
    output logic                        ovf,
    output logic                        carry
);
    localparam int W    = `EXEC_DATA_WIDTH;
    localparam int AmtW = $clog2(W);

    logic [W-1:0]    addA;
    logic [W-1:0]    addB;
    logic            cIn;
    logic [W-1:0]    sum;
    logic            cOut;
    logic            rawOvf;
    logic            isArith;
    logic [AmtW-1:0] amt;
    logic [2*W-1:0]  rolWide;
    logic [2*W-1:0]  rorWide;

    // SUB gives inB minus inA, invertB gives inA minus inB
    assign addA = (aluOp == SUB) ? ~inA : inA;
    assign addB = invertB ? ~inB : inB;
    assign cIn  = (aluOp == SUB) || invertB;

    assign {cOut, sum} = addA + addB + cIn;

    assign rawOvf  = (addA[W-1] == addB[W-1]) && (sum[W-1] != addA[W-1]);
    assign isArith = (aluOp == ADD) || (aluOp == SUB);

    // Shift amount comes from the low bits of inB
    assign amt     = inB[AmtW-1:0];
    assign rolWide = {inA, inA} << amt;
    assign rorWide = {inA, inA} >> amt;

    always_comb begin
        case (aluOp)
            ADD, SUB: out = sum;
            XOR:      out = inA ^ inB;
            ANDN:     out = inA & ~inB;
            ROL:      out = rolWide[2*W-1:W];
            SLL:      out = inA << amt;
            ROR:      out = rorWide[W-1:0];
            SRL:      out = inA >> amt;
            default:  out = sum;
        endcase
    end

    assign ovf   = isArith && rawOvf;
    assign carry = isArith && cOut;

    // Flags of add and subtract follow the true signed result
    always_comb begin
        if (isArith) begin
            zero = (sum == '0) && !rawOvf;
            ltz  = sum[W-1] ^ rawOvf;
        end else begin
            zero = (out == '0);
            ltz  = out[W-1];
        end
    end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "execCore_settings.svh"

module executeStage import execPkg::*; (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        stall,
    execBus.sink                        busOut,
    output logic                        pop,
    output logic                        resultValid,
    output logic [`EXEC_DATA_WIDTH-1:0] result,
    output logic [2:0]                  destReg,
    output logic                        zero,
    output logic                        ltz,
    output logic                        err
);
    localparam int W = `EXEC_DATA_WIDTH;

    logic [W-1:0] aluB;
    logic [W-1:0] aluOut;
    logic         aluZero;
    logic         aluLtz;
    logic         aluOvf;
    logic         aluCarry;
    logic         setBit;
    logic [W-1:0] reversed;
    logic [W-1:0] byteImm;
    logic [W-1:0] resVal;
    logic         errNext;

    assign pop = busOut.valid && !stall;

    // Branches compare rs against zero
    assign aluB = busOut.isBranch ? '0 : busOut.opB;

    aluCore uAlu (
        .inA     (busOut.opA),
        .inB     (aluB),
        .aluOp   (busOut.aluOp),
        .invertB (busOut.invertB),
        .out     (aluOut),
        .zero    (aluZero),
        .ltz     (aluLtz),
        .ovf     (aluOvf),
        .carry   (aluCarry)
    );

    always_comb begin
        case (busOut.setCond)
            EQ:      setBit = aluZero;
            LT:      setBit = aluLtz;
            LE:      setBit = aluZero || aluLtz;
            default: setBit = aluCarry;
        endcase
    end

    always_comb begin
        for (int i = 0; i < W; i++) begin
            reversed[i] = busOut.opA[W-1-i];
        end
    end

    // useImm marks SLBI, otherwise LBI
    assign byteImm = busOut.useImm ? ((busOut.opA << 8) | busOut.immVal) : busOut.immVal;

    always_comb begin
        case (busOut.resultSel)
            ALU:     resVal = aluOut;
            SET:     resVal = {{(W-1){1'b0}}, setBit};
            REVERSE: resVal = reversed;
            default: resVal = byteImm;
        endcase
    end

    assign errNext = aluOvf && (busOut.resultSel == ALU);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            zero        <= 1'b0;
            ltz         <= 1'b0;
            err         <= 1'b0;
        end else begin
            resultValid <= pop;
            if (pop) begin
                zero <= aluZero;
                ltz  <= aluLtz;
                err  <= errNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result  <= busOut.isBranch ? '0 : resVal;
            destReg <= busOut.destReg;
        end
    end

    // The two subtract forms never reach the ALU together
    assert property (@(posedge clk) disable iff (!rstN)
        pop |-> !(busOut.invertB && (busOut.aluOp == SUB)));

endmodule

`default_nettype wire

// ==== execCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "execCore_settings.svh"

module execCore import execPkg::*; (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        instrValid,
    input  instrWordT                   instr,
    input  logic [`EXEC_DATA_WIDTH-1:0] rsData,
    input  logic [`EXEC_DATA_WIDTH-1:0] rtData,
    input  logic                        stall,
    output logic                        full,
    output logic                        resultValid,
    output logic [`EXEC_DATA_WIDTH-1:0] result,
    output logic [2:0]                  destReg,
    output logic                        zero,
    output logic                        ltz,
    output logic                        err
);
    logic pop;

    execBus busIn ();
    execBus busOut ();

    instrDecoder uDecoder (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rsData     (rsData),
        .rtData     (rtData),
        .busIn      (busIn.source)
    );

    opQueue uQueue (
        .clk    (clk),
        .rstN   (rstN),
        .pop    (pop),
        .busIn  (busIn.sink),
        .busOut (busOut.source),
        .full   (full)
    );

    executeStage uExecute (
        .clk         (clk),
        .rstN        (rstN),
        .stall       (stall),
        .busOut      (busOut.sink),
        .pop         (pop),
        .resultValid (resultValid),
        .result      (result),
        .destReg     (destReg),
        .zero        (zero),
        .ltz         (ltz),
        .err         (err)
    );

endmodule

`default_nettype wire

// ==== tb_execCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "execCore_settings.svh"

module tb_execCore import execPkg::*; ();
    localparam int W = `EXEC_DATA_WIDTH;
    localparam int NumR = 200;
    localparam int NumI = 200;
    localparam int NumMisc = 88;
    localparam int MaxBackPressure = 20;
    localparam int NumMix = 300;
    localparam int TotalOps = NumR + NumI + NumMisc + MaxBackPressure + NumMix;
    localparam int TimeoutCycles = 4 * TotalOps + 200;

    typedef struct packed {
        logic [W-1:0] out;
        logic         zero;
        logic         ltz;
        logic         ovf;
        logic         carry;
    } aluResT;

    typedef struct packed {
        logic [W-1:0] result;
        logic [2:0]   dest;
        logic         zero;
        logic         ltz;
        logic         err;
    } expT;

    logic         clk;
    logic         rstN;
    logic         instrValid;
    instrWordT    instr;
    logic [W-1:0] rsData;
    logic [W-1:0] rtData;
    logic         stall;
    logic         full;
    logic         resultValid;
    logic [W-1:0] result;
    logic [2:0]   destReg;
    logic         zero;
    logic         ltz;
    logic         err;

    expT         expQ [$];
    int          edgeQ [$];
    int          cycleCnt = 0;
    int unsigned lcgState = 16069;
    string       testName = "reset";
    int          testErrors = 0;
    int          testChecked = 0;
    int          testIssued = 0;
    int          totalErrors = 0;
    int          totalChecked = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    logic        checkLatency = 1'b0;
    logic        stallPhase = 1'b0;

    opcodeT rOps [8] = '{ADDR, SUBR, XORR, ANDNR, ROLR, SLLR, RORR, SRLR};
    opcodeT iOps [8] = '{ADDI, SUBI, XORI, ANDNI, ROLI, SLLI, RORI, SRLI};
    opcodeT miscOps [11] = '{SEQ, SLT, SLE, SCO, BTR, LBI, SLBI, BEQZ, BNEZ, BLTZ, BGEZ};
    logic [W-1:0] corners [8] = '{16'h0000, 16'h0001, 16'hFFFF, 16'h8000,
                                  16'h7FFF, 16'h00FF, 16'h5A5A, 16'hA5C3};
    logic [4:0] immEdges [5] = '{5'h00, 5'h01, 5'h0F, 5'h10, 5'h1F};

    execCore i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .rsData      (rsData),
        .rtData      (rtData),
        .stall       (stall),
        .full        (full),
        .resultValid (resultValid),
        .result      (result),
        .destReg     (destReg),
        .zero        (zero),
        .ltz         (ltz),
        .err         (err)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    always @(posedge clk) begin
        if (cycleCnt >= TimeoutCycles) begin
            $display("Timeout after %0d cycles in %s", cycleCnt, testName);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [W-1:0] nextRand();
        lcgState = lcgState * 1103515245 + 12345;
        return lcgState[30:15];
    endfunction

    function automatic aluOpT funcOf(opcodeT op);
        case (op)
            ADDR, ADDI:   return ADD;
            SUBR, SUBI:   return SUB;
            XORR, XORI:   return XOR;
            ANDNR, ANDNI: return ANDN;
            ROLR, ROLI:   return ROL;
            SLLR, SLLI:   return SLL;
            RORR, RORI:   return ROR;
            default:      return SRL;
        endcase
    endfunction

    // Arithmetic is done on full integers so flags follow the true signed value
    function automatic aluResT aluRef(aluOpT f, logic [W-1:0] a, logic [W-1:0] b,
                                      logic aMinusB);
        aluResT    r;
        int        sa;
        int        sb;
        int        s;
        logic [W:0] u;
        logic [3:0] amt;
        sa = {{16{a[15]}}, a};
        sb = {{16{b[15]}}, b};
        amt = b[3:0];
        u = {1'b0, a} + {1'b0, b};
        r = '0;
        if (aMinusB || f == ADD || f == SUB) begin
            if (aMinusB) begin
                s = sa - sb;
            end else if (f == SUB) begin
                // Subtract takes the first operand from the second
                s = sb - sa;
            end else begin
                s = sa + sb;
                r.carry = u[W];
            end
            r.out = s[15:0];
            r.zero = (s == 0);
            r.ltz = (s < 0);
            r.ovf = (s > 32767) || (s < -32768);
        end else begin
            case (f)
                XOR:  r.out = a ^ b;
                ANDN: r.out = a & ~b;
                ROL:  r.out = (amt == 4'd0) ? a : ((a << amt) | (a >> (5'd16 - {1'b0, amt})));
                SLL:  r.out = a << amt;
                ROR:  r.out = (amt == 4'd0) ? a : ((a >> amt) | (a << (5'd16 - {1'b0, amt})));
                default: r.out = a >> amt;
            endcase
            r.zero = (r.out == '0);
            r.ltz = r.out[W-1];
        end
        return r;
    endfunction

    function automatic expT refModel(instrWordT w, logic [W-1:0] rs, logic [W-1:0] rt);
        expT        e;
        aluResT     r;
        opcodeT     op;
        logic [W-1:0] imm5s;
        logic [W-1:0] imm5z;
        logic [W-1:0] imm8s;
        logic [W-1:0] imm8z;
        op = w.rForm.opcode;
        imm5s = {{11{w.iForm.imm5[4]}}, w.iForm.imm5};
        imm5z = {11'b0, w.iForm.imm5};
        imm8s = {{8{w.jForm.imm8[7]}}, w.jForm.imm8};
        imm8z = {8'b0, w.jForm.imm8};
        e = '0;
        e.dest = w.rForm.rd;
        case (op)
            ADDR, SUBR, XORR, ANDNR, ROLR, SLLR, RORR, SRLR: begin
                r = aluRef(funcOf(op), rs, rt, 1'b0);
                e.result = r.out;
                e.err = r.ovf;
            end
            ADDI, SUBI, XORI, ANDNI, ROLI, SLLI, RORI, SRLI: begin
                r = aluRef(funcOf(op), rs, (op == ANDNI) ? imm5z : imm5s, 1'b0);
                e.result = r.out;
                e.err = r.ovf;
                e.dest = w.iForm.rd;
            end
            SEQ, SLT, SLE: begin
                r = aluRef(ADD, rs, rt, 1'b1);
                if (op == SEQ) begin
                    e.result = {15'b0, r.zero};
                end else if (op == SLT) begin
                    e.result = {15'b0, r.ltz};
                end else begin
                    e.result = {15'b0, r.zero | r.ltz};
                end
            end
            SCO: begin
                r = aluRef(ADD, rs, rt, 1'b0);
                e.result = {15'b0, r.carry};
            end
            BTR: begin
                r = aluRef(ADD, rs, rt, 1'b0);
                e.result = {<<{rs}};
            end
            LBI: begin
                r = aluRef(ADD, rs, rt, 1'b0);
                e.result = imm8s;
                e.dest = w.jForm.rs;
            end
            SLBI: begin
                r = aluRef(ADD, rs, imm8z, 1'b0);
                e.result = {rs[7:0], w.jForm.imm8};
                e.dest = w.jForm.rs;
            end
            default: begin
                // Branches only compare rs with zero
                r = aluRef(ADD, rs, '0, 1'b0);
                e.dest = 3'd0;
            end
        endcase
        e.zero = r.zero;
        e.ltz = r.ltz;
        return e;
    endfunction

    task automatic noteError();
        testErrors++;
        totalErrors++;
    endtask

    // Compare results and record issued operations between clock edges
    always @(negedge clk) begin
        expT e;
        int  se;
        if (rstN) begin
            if (resultValid) begin
                if (stallPhase) begin
                    $display("%s: a result came out while stall was held", testName);
                    noteError();
                end
                if (expQ.size() == 0) begin
                    $display("%s: result arrived with no operation outstanding", testName);
                    noteError();
                end else begin
                    e = expQ.pop_front();
                    se = edgeQ.pop_front();
                    testChecked++;
                    totalChecked++;
                    if (result !== e.result) begin
                        $display("[FAIL] %s: result expected %h actual %h",
                                 testName, e.result, result);
                        noteError();
                    end
                    if (destReg !== e.dest) begin
                        $display("[FAIL] %s: destReg expected %0d actual %0d",
                                 testName, e.dest, destReg);
                        noteError();
                    end
                    if (zero !== e.zero) begin
                        $display("[FAIL] %s: zero expected %b actual %b", testName, e.zero, zero);
                        noteError();
                    end
                    if (ltz !== e.ltz) begin
                        $display("[FAIL] %s: ltz expected %b actual %b", testName, e.ltz, ltz);
                        noteError();
                    end
                    if (err !== e.err) begin
                        $display("[FAIL] %s: err expected %b actual %b", testName, e.err, err);
                        noteError();
                    end
                    if (checkLatency && (cycleCnt - se != 2)) begin
                        $display("[FAIL] %s: latency expected 2 actual %0d",
                                 testName, cycleCnt - se);
                        noteError();
                    end
                end
            end
            if (instrValid) begin
                expQ.push_back(refModel(instr, rsData, rtData));
                edgeQ.push_back(cycleCnt + 1);
                testIssued++;
            end
        end
    end

    task automatic driveOp(opcodeT op, logic [10:0] rest, logic [W-1:0] a, logic [W-1:0] b);
        instrValid <= 1'b1;
        instr <= {op, rest};
        rsData <= a;
        rtData <= b;
    endtask

    task automatic sendOp(opcodeT op, logic [10:0] rest, logic [W-1:0] a, logic [W-1:0] b);
        @(posedge clk);
        driveOp(op, rest, a, b);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    task automatic startTest(string name);
        testName = name;
        testErrors = 0;
        testChecked = 0;
        testIssued = 0;
    endtask

    task automatic finishTest();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("%s: %0d results never arrived", testName, expQ.size());
            noteError();
        end
        // Extra cycles catch duplicated results
        repeat (5) @(negedge clk);
        if (testChecked != testIssued) begin
            $display("%s: %0d operations issued but %0d results seen",
                     testName, testIssued, testChecked);
            noteError();
        end
        $display("%s: %0d results checked, %0d errors", testName, testChecked, testErrors);
        if (testErrors == 0) begin
            testsPassed++;
        end else begin
            testsFailed++;
        end
    endtask

    initial begin
        logic [W-1:0] r;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic         ok;
        logic         h1;
        logic         h2;
        logic         seen;
        int           n;
        int           sent;
        clk = 1'b0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        rsData = '0;
        rtData = '0;
        stall = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        startTest("idle after reset");
        repeat (10) begin
            @(negedge clk);
            if (resultValid !== 1'b0 || full !== 1'b0 || err !== 1'b0) begin
                $display("%s: resultValid, full or err is not low", testName);
                noteError();
            end
        end
        finishTest();

        startTest("R-format ALU");
        checkLatency = 1'b1;
        for (int i = 0; i < NumR; i++) begin
            r = nextRand();
            a = (i % 5 == 0) ? corners[i % 8] : nextRand();
            b = (i % 7 == 0) ? corners[(i / 7) % 8] : nextRand();
            sendOp(rOps[i % 8], r[10:0], a, b);
        end
        idleCycle();
        finishTest();
        checkLatency = 1'b0;

        startTest("immediate ALU");
        for (int i = 0; i < NumI; i++) begin
            r = nextRand();
            if (i % 2 == 0) begin
                r[4:0] = immEdges[(i / 2) % 5];
            end
            a = (i % 2 == 0) ? corners[(i / 16) % 8] : nextRand();
            sendOp(iOps[(i / 2) % 8], r[10:0], a, nextRand());
        end
        idleCycle();
        finishTest();

        startTest("set, reverse, byte and branch");
        for (int i = 0; i < NumMisc; i++) begin
            r = nextRand();
            a = corners[(i / 11) % 8];
            b = (i % 2 == 1) ? a : corners[(i / 3) % 8];
            sendOp(miscOps[i % 11], r[10:0], a, b);
        end
        idleCycle();
        finishTest();

        startTest("back-pressure");
        @(posedge clk);
        stall <= 1'b1;
        repeat (3) @(posedge clk);
        stallPhase = 1'b1;
        h1 = 1'b0;
        h2 = 1'b0;
        seen = 1'b0;
        n = 0;
        // An op may be issued only if none was issued two cycles before
        while (!seen && n < MaxBackPressure) begin
            @(posedge clk);
            n++;
            if (full) begin
                seen = 1'b1;
                instrValid <= 1'b0;
            end else begin
                ok = !h2;
                r = nextRand();
                if (ok) begin
                    driveOp(rOps[n % 8], r[10:0], nextRand(), nextRand());
                end else begin
                    instrValid <= 1'b0;
                end
                h2 = h1;
                h1 = ok;
            end
        end
        if (!seen) begin
            $display("%s: full never rose while stall was held", testName);
            noteError();
        end
        repeat (4) @(posedge clk);
        stallPhase = 1'b0;
        stall <= 1'b0;
        finishTest();

        startTest("random mix with stall");
        sent = 0;
        h1 = 1'b0;
        h2 = 1'b0;
        while (sent < NumMix) begin
            @(posedge clk);
            r = nextRand();
            stall <= r[0];
            ok = !full && !h2 && r[1];
            if (ok) begin
                a = nextRand();
                case (r[3:2])
                    2'd0: driveOp(rOps[r[6:4] % 8], a[10:0], nextRand(), nextRand());
                    2'd1: driveOp(iOps[r[6:4] % 8], a[10:0], nextRand(), nextRand());
                    default: driveOp(miscOps[r[7:4] % 11], a[10:0], corners[r[10:8]],
                                     nextRand());
                endcase
                sent++;
            end else begin
                instrValid <= 1'b0;
            end
            h2 = h1;
            h1 = ok;
        end
        @(posedge clk);
        instrValid <= 1'b0;
        stall <= 1'b0;
        finishTest();

        $display("%0d tests passed, %0d tests failed, %0d results checked, %0d errors",
                 testsPassed, testsFailed, totalChecked, totalErrors);
        if (totalErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== execCore.f ====
+incdir+.
execPkg.sv
execBus.sv
instrDecoder.sv
opQueue.sv
aluCore.sv
executeStage.sv
execCore.sv
tb_execCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f execCore.f --top-module tb_execCore -o simExecCore
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output="$(./obj_dir/simExecCore)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
